/* src.f */
hw/ethpipe_pkg.sv
hw/wb_target_mux.sv
hw/ethpipe_regs.sv
hw/tx_slot_mem.sv
hw/slot_sender.sv
hw/ethpipe_top.sv
testbench/tb_ethpipe.sv
+incdir+testbench

/* run_sim.sh */
#!/usr/bin/env bash
# build and run tb_ethpipe with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_ethpipe -f src.f -o tb_ethpipe > build.log 2>&1 \
  && ./obj_dir/tb_ethpipe > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "simulation reported failures, see sim.log"; exit 1; }
echo "simulation finished without failures"
exit 0

/* testbench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------------------------------------
// address helpers
// --------------------------------------------------
function automatic logic [WB_AW-1:0] reg_adr(input logic [7:0] off);
  return {7'b0, off};
endfunction

// top address bit selects the slot memory
function automatic logic [WB_AW-1:0] slot_adr(input logic [SLOT_AW-1:0] a);
  logic [WB_AW-1:0] adr;
  adr              = '0;
  adr[WB_AW-1]     = 1'b1;
  adr[SLOT_AW-1:0] = a;
  return adr;
endfunction

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic cmp_data(input string what, input logic [WB_DW-1:0] got,
                        input logic [WB_DW-1:0] exp);
  if (got !== exp) begin
    $display("error @ %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic cmp_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    $display("error @ %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic cmp_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error @ %0t: %s got %b expected %b", $time, what, got, exp);
    errors++;
  end
endtask

// --------------------------------------------------
// bus master
// --------------------------------------------------
// starts and ends on a falling edge with one idle cycle after ack
task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                         input logic [WB_DW-1:0] dat, input logic [WB_SW-1:0] sel,
                         output logic [WB_DW-1:0] rdat);
  int n;
  wb_req = '{we: we, adr: adr, dat: dat, sel: sel};
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  n      = 0;
  do begin
    @(negedge clk_125);
    n++;
  end while (wb_rsp.ack !== 1'b1 && n < TMO);
  if (wb_rsp.ack !== 1'b1) begin
    $display("timeout: no ack from address %h after %0d cycles", adr, TMO);
    timeouts++;
  end else begin
    // target acks in the cycle after it samples the strobe
    cmp_data($sformatf("cycles from strobe to ack at %h", adr), WB_DW'(n), 16'd1);
  end
  rdat   = wb_rsp.dat;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  @(negedge clk_125);
  // ack is a single-cycle pulse
  cmp_bit($sformatf("ack one cycle after ack at %h", adr), wb_rsp.ack, 1'b0);
endtask

task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat,
                        input logic [WB_SW-1:0] sel);
  logic [WB_DW-1:0] unused;
  bus_cycle(1'b1, adr, dat, sel, unused);
endtask

task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
  bus_cycle(1'b0, adr, '0, 2'b11, dat);
endtask

task automatic wait_tx(input logic level);
  int n;
  n = 0;
  while (tx_en !== level && n < TMO) begin
    @(negedge clk_125);
    n++;
  end
  if (tx_en !== level) begin
    $display("timeout: tx_en_o did not reach %0b within %0d cycles", level, TMO);
    timeouts++;
  end
endtask

// low 32 bits with a re-read when the upper half moved in between
task automatic read_cnt(output logic [31:0] v);
  logic [WB_DW-1:0] hi;
  logic [WB_DW-1:0] lo;
  logic [WB_DW-1:0] hi2;
  wb_read(reg_adr(REG_CNT1), hi);
  wb_read(reg_adr(REG_CNT0), lo);
  wb_read(reg_adr(REG_CNT1), hi2);
  if (hi2 != hi) begin
    wb_read(reg_adr(REG_CNT0), lo);
  end
  v = {hi2, lo};
endtask

// load n words from base, move the write pointer, check the stream
task automatic send_burst(input int base, input int n);
  logic [WB_DW-1:0] words [$];
  logic [WB_DW-1:0] w;
  for (int i = 0; i < n; i++) begin
    w = WB_DW'($urandom);
    words.push_back(w);
    wb_write(slot_adr(SLOT_AW'(base + i)), w, 2'b11);
  end
  rx_bytes.delete();
  bursts = 0;
  read_cnt(cnt_before);
  wb_write(reg_adr(REG_TX_WR_PTR), WB_DW'(base + n), 2'b11);
  wait_tx(1'b1);
  wait_tx(1'b0);
  read_cnt(cnt_after);
  cmp_data("bursts seen", WB_DW'(bursts), 16'd1);
  cmp_data("bytes collected", WB_DW'(rx_bytes.size()), WB_DW'(2 * n));
  if (rx_bytes.size() == 2 * n) begin
    for (int i = 0; i < n; i++) begin
      cmp_byte($sformatf("high byte of word %0d", base + i), rx_bytes[2*i], words[i][15:8]);
      cmp_byte($sformatf("low byte of word %0d", base + i), rx_bytes[2*i+1], words[i][7:0]);
    end
  end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic reset_state();
  logic [WB_DW-1:0] d;
  cmp_bit("tx_en_o after reset", tx_en, 1'b0);
  cmp_bit("intr_o after reset", intr, 1'b0);
  cmp_byte("txd_o after reset", txd, 8'h00);
  wb_read(reg_adr(REG_STATUS), d);
  cmp_data("status after reset", d, 16'h0000);
  wb_read(reg_adr(REG_TX_WR_PTR), d);
  cmp_data("write pointer after reset", d, 16'h0000);
  wb_read(reg_adr(REG_TX_RD_PTR), d);
  cmp_data("read pointer after reset", d, 16'h0000);
  wb_read(reg_adr(REG_STAMP0), d);
  cmp_data("timestamp after reset", d, 16'h0000);
  wb_read(reg_adr(8'h40), d);
  cmp_data("unmapped offset", d, 16'h0000);
endtask

// one address per 128-word block, so no two collide
task automatic slot_rw();
  logic [SLOT_AW-1:0] addr [8];
  logic [WB_DW-1:0]   want [8];
  logic [WB_DW-1:0]   w1;
  logic [WB_DW-1:0]   w2;
  logic [WB_DW-1:0]   d;
  for (int i = 0; i < 8; i++) begin
    addr[i] = SLOT_AW'(i * 128 + int'($urandom % 128));
    w1      = WB_DW'($urandom);
    w2      = WB_DW'($urandom);
    wb_write(slot_adr(addr[i]), w1, 2'b11);
    if (i % 2 == 0) begin
      wb_write(slot_adr(addr[i]), w2, 2'b10);
      want[i] = {w2[15:8], w1[7:0]};
    end else begin
      wb_write(slot_adr(addr[i]), w2, 2'b01);
      want[i] = {w1[15:8], w2[7:0]};
    end
  end
  for (int i = 0; i < 8; i++) begin
    wb_read(slot_adr(addr[i]), d);
    cmp_data($sformatf("slot word %0d", addr[i]), d, want[i]);
  end
endtask

task automatic counter_runs();
  logic [31:0]      c0;
  logic [31:0]      c1;
  logic [WB_DW-1:0] d;
  read_cnt(c0);
  read_cnt(c1);
  cmp_bit("counter increasing", c1 > c0, 1'b1);
  wb_read(reg_adr(REG_CNT3), d);
  cmp_data("counter bits 63:48", d, 16'h0000);
endtask

task automatic transmit_burst();
  int               n;
  logic [WB_DW-1:0] d;
  n = 6 + int'($urandom % 6);
  send_burst(0, n);
  tx_ptr = n;
  wb_read(reg_adr(REG_TX_RD_PTR), d);
  cmp_data("read pointer after burst", d, WB_DW'(n));
  wb_read(reg_adr(REG_STATUS), d);
  cmp_bit("busy after burst", d[STAT_BUSY], 1'b0);
endtask

// stamp lies between the two counter reads around the burst
task automatic stamp_window();
  logic [WB_DW-1:0]   s0;
  logic [WB_DW-1:0]   s1;
  logic [WB_DW-1:0]   s2;
  logic [STAMP_W-1:0] stamp;
  wb_read(reg_adr(REG_STAMP0), s0);
  wb_read(reg_adr(REG_STAMP1), s1);
  wb_read(reg_adr(REG_STAMP2), s2);
  stamp = {s2, s1, s0};
  cmp_bit("timestamp nonzero", stamp != '0, 1'b1);
  cmp_bit("timestamp above earlier counter", stamp > {16'h0, cnt_before}, 1'b1);
  cmp_bit("timestamp below later counter", stamp < {16'h0, cnt_after}, 1'b1);
endtask

task automatic done_and_irq();
  logic [WB_DW-1:0] d;
  cmp_bit("intr_o after burst", intr, 1'b1);
  wb_read(reg_adr(REG_STATUS), d);
  cmp_bit("done bit after burst", d[STAT_DONE], 1'b1);
  wb_write(reg_adr(REG_STATUS), 16'h0000, 2'b01);
  cmp_bit("intr_o after clear", intr, 1'b0);
  wb_read(reg_adr(REG_STATUS), d);
  cmp_bit("done bit after clear", d[STAT_DONE], 1'b0);
  send_burst(tx_ptr, 3);
  tx_ptr = tx_ptr + 3;
  wb_read(reg_adr(REG_STATUS), d);
  cmp_bit("done bit after second burst", d[STAT_DONE], 1'b1);
  cmp_bit("intr_o after second burst", intr, 1'b1);
endtask

`endif

/* testbench/tb_ethpipe.sv */
`timescale 1ns/100ps

module tb_ethpipe;
  import ethpipe_pkg::*;

  localparam int SLOT_AW = 10;
  // cycles any single wait may take
  localparam int TMO     = 200;

  logic       clk_125;
  logic       sys_rst;
  logic       wb_cyc;
  logic       wb_stb;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       tx_en;
  logic [7:0] txd;
  logic       intr;

  int          errors;
  int          timeouts;
  int          bursts;
  int          tx_ptr;
  logic        tx_en_prev;
  logic [31:0] cnt_before;
  logic [31:0] cnt_after;
  logic [7:0]  rx_bytes [$];

  `include "tb_tasks.svh"

  // --------------------------------------------------
  // DUT
  // --------------------------------------------------
  ethpipe_top #(.SLOT_AW(SLOT_AW)) dut_i (
    .clk_125  (clk_125),
    .sys_rst  (sys_rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .tx_en_o  (tx_en),
    .txd_o    (txd),
    .intr_o   (intr)
  );

  // 40 ns period
  always #20 clk_125 = ~clk_125;

  // --------------------------------------------------
  // byte collector
  // --------------------------------------------------
  // sampled on the falling edge, away from the DUT's updates
  always @(negedge clk_125) begin
    if (tx_en === 1'b1) begin
      rx_bytes.push_back(txd);
      // rising tx_en starts a new burst
      if (tx_en_prev !== 1'b1) begin
        bursts++;
      end
    end
    tx_en_prev = tx_en;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    errors     = 0;
    timeouts   = 0;
    bursts     = 0;
    tx_ptr     = 0;
    tx_en_prev = 1'b0;
    cnt_before = '0;
    cnt_after  = '0;
    clk_125    = 1'b0;
    sys_rst    = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_req     = '0;
    void'($urandom(91));

    repeat (10) @(negedge clk_125);
    sys_rst = 1'b0;

    reset_state();
    slot_rw();
    counter_runs();
    transmit_burst();
    stamp_window();
    done_and_irq();

    @(negedge clk_125);
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hw/ethpipe_top.sv */
`timescale 1ns/100ps

module ethpipe_top #(
  parameter int SLOT_AW = 10
) (
  input  logic                 clk_125,
  input  logic                 sys_rst,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  ethpipe_pkg::wb_req_t wb_req_i,
  output ethpipe_pkg::wb_rsp_t wb_rsp_o,
  output logic                 tx_en_o,
  output logic [7:0]           txd_o,
  output logic                 intr_o
);
  import ethpipe_pkg::*;

  logic               reg_stb;
  logic               mem_stb;
  wb_rsp_t            reg_rsp;
  wb_rsp_t            mem_rsp;
  logic [SLOT_AW-1:0] wr_ptr;
  logic [SLOT_AW-1:0] rd_ptr;
  logic [SLOT_AW-1:0] rd_addr;
  logic [15:0]        rd_data;
  logic               stamp_req;
  logic               done;

  // --------------------------------------------------
  // bus side
  // --------------------------------------------------
  wb_target_mux u_mux (
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_req_i  (wb_req_i),
    .reg_rsp_i (reg_rsp),
    .mem_rsp_i (mem_rsp),
    .reg_stb_o (reg_stb),
    .mem_stb_o (mem_stb),
    .wb_rsp_o  (wb_rsp_o)
  );

  ethpipe_regs #(.SLOT_AW(SLOT_AW)) u_regs (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .stb_i       (reg_stb),
    .req_i       (wb_req_i),
    .rd_ptr_i    (rd_ptr),
    .stamp_req_i (stamp_req),
    .done_i      (done),
    .rsp_o       (reg_rsp),
    .wr_ptr_o    (wr_ptr),
    .intr_o      (intr_o)
  );

  tx_slot_mem #(.SLOT_AW(SLOT_AW)) u_slot (
    .clk_125   (clk_125),
    .sys_rst   (sys_rst),
    .stb_i     (mem_stb),
    .req_i     (wb_req_i),
    .rd_addr_i (rd_addr),
    .rsp_o     (mem_rsp),
    .rd_data_o (rd_data)
  );

  // transmit side
  slot_sender #(.SLOT_AW(SLOT_AW)) u_sender (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .wr_ptr_i    (wr_ptr),
    .rd_data_i   (rd_data),
    .rd_addr_o   (rd_addr),
    .rd_ptr_o    (rd_ptr),
    .tx_en_o     (tx_en_o),
    .txd_o       (txd_o),
    .stamp_req_o (stamp_req),
    .done_o      (done)
  );

endmodule

/* hw/slot_sender.sv */
`timescale 1ns/100ps

module slot_sender #(
  parameter int SLOT_AW = 10
) (
  input  logic               clk_125,
  input  logic               sys_rst,
  input  logic [SLOT_AW-1:0] wr_ptr_i,
  input  logic [15:0]        rd_data_i,
  output logic [SLOT_AW-1:0] rd_addr_o,
  output logic [SLOT_AW-1:0] rd_ptr_o,
  output logic               tx_en_o,
  output logic [7:0]         txd_o,
  output logic               stamp_req_o,
  output logic               done_o
);
  import ethpipe_pkg::*;

  sender_state_e      state_q;
  logic [SLOT_AW-1:0] rd_ptr_q;
  logic [SLOT_AW-1:0] ptr_nxt;
  logic               pending;

  // wraps modulo slot size
  assign ptr_nxt = rd_ptr_q + 1'b1;
  assign pending = (rd_ptr_q != wr_ptr_i);

  // prefetch next word while the low byte goes out
  assign rd_addr_o = (state_q == S_LOW) ? ptr_nxt : rd_ptr_q;
  assign rd_ptr_o  = rd_ptr_q;

  // --------------------------------------------------
  // sender FSM, registered byte stream
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q     <= S_IDLE;
      rd_ptr_q    <= '0;
      tx_en_o     <= 1'b0;
      txd_o       <= 8'h00;
      stamp_req_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      stamp_req_o <= 1'b0;
      done_o      <= 1'b0;
      case (state_q)
        S_IDLE: begin
          tx_en_o <= 1'b0;
          txd_o   <= 8'h00;
          // still high here only right after the last low byte
          done_o  <= tx_en_o;
          if (pending) begin
            state_q <= S_FETCH;
          end
        end
        S_FETCH: begin
          // read of rd_ptr in flight
          state_q <= S_HIGH;
        end
        S_HIGH: begin
          tx_en_o     <= 1'b1;
          txd_o       <= rd_data_i[15:8];
          // first high byte of a burst
          stamp_req_o <= ~tx_en_o;
          state_q     <= S_LOW;
        end
        S_LOW: begin
          // memory still holds the word read in S_HIGH
          tx_en_o  <= 1'b1;
          txd_o    <= rd_data_i[7:0];
          rd_ptr_q <= ptr_nxt;
          if (ptr_nxt != wr_ptr_i) begin
            state_q <= S_HIGH;
          end else begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

endmodule

/* hw/tx_slot_mem.sv */
`timescale 1ns/100ps

module tx_slot_mem #(
  parameter int SLOT_AW = 10
) (
  input  logic                 clk_125,
  input  logic                 sys_rst,
  input  logic                 stb_i,
  input  ethpipe_pkg::wb_req_t req_i,
  input  logic [SLOT_AW-1:0]   rd_addr_i,
  output ethpipe_pkg::wb_rsp_t rsp_o,
  output logic [15:0]          rd_data_o
);
  import ethpipe_pkg::*;

  localparam int DEPTH = 2 ** SLOT_AW;

  logic [WB_DW-1:0]   mem [DEPTH];
  logic [SLOT_AW-1:0] bus_addr;
  logic [WB_DW-1:0]   bus_q;
  logic               ack_q;
  logic               access;

  assign bus_addr = req_i.adr[SLOT_AW-1:0];
  assign access   = stb_i & ~ack_q;

  // --------------------------------------------------
  // bus port, byte lane writes and registered read
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (access) begin
      if (req_i.we) begin
        for (int b = 0; b < WB_SW; b++) begin
          if (req_i.sel[b]) begin
            mem[bus_addr][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
      bus_q <= mem[bus_addr];
    end
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // sender port, one cycle latency
  always_ff @(posedge clk_125) begin
    rd_data_o <= mem[rd_addr_i];
  end

  assign rsp_o = '{ack: ack_q, dat: bus_q};

endmodule

/* hw/ethpipe_regs.sv */
`timescale 1ns/100ps

module ethpipe_regs #(
  parameter int SLOT_AW = 10
) (
  input  logic                 clk_125,
  input  logic                 sys_rst,
  input  logic                 stb_i,
  input  ethpipe_pkg::wb_req_t req_i,
  input  logic [SLOT_AW-1:0]   rd_ptr_i,
  input  logic                 stamp_req_i,
  input  logic                 done_i,
  output ethpipe_pkg::wb_rsp_t rsp_o,
  output logic [SLOT_AW-1:0]   wr_ptr_o,
  output logic                 intr_o
);
  import ethpipe_pkg::*;

  logic [CNT_W-1:0]   cnt_q;
  logic [7:1]         status_q;
  logic [7:0]         status_rd;
  logic [SLOT_AW-1:0] wr_ptr_q;
  logic [STAMP_W-1:0] stamp_q;
  logic               ack_q;
  logic [WB_DW-1:0]   rd_q;
  logic [WB_DW-1:0]   rd_val;
  logic               access;
  logic               wr_access;
  logic               busy;
  reg_addr_e          offset;

  // one access per strobe, the ack cycle is not sampled again
  assign access    = stb_i & ~ack_q;
  assign wr_access = access & req_i.we;
  assign offset    = reg_addr_e'(req_i.adr[7:0]);

  // sender still has words between the pointers
  assign busy = (rd_ptr_i != wr_ptr_q);

  // --------------------------------------------------
  // free-running counter
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // control registers
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status_q <= '0;
      wr_ptr_q <= '0;
      stamp_q  <= '0;
    end else begin
      // low lane carries status bits 7:1, bit 0 is busy
      if (wr_access && offset == REG_STATUS && req_i.sel[0]) begin
        status_q <= req_i.dat[7:1];
      end
      // done from the sender wins over a clearing write
      if (done_i) begin
        status_q[STAT_DONE] <= 1'b1;
      end
      // pointer only moves on a full word write
      if (wr_access && offset == REG_TX_WR_PTR && (&req_i.sel)) begin
        wr_ptr_q <= req_i.dat[SLOT_AW-1:0];
      end
      // counter sampled on the first byte of a burst
      if (stamp_req_i) begin
        stamp_q <= cnt_q[STAMP_W-1:0];
      end
    end
  end

  // --------------------------------------------------
  // read path
  // --------------------------------------------------
  always_comb begin
    status_rd            = {status_q, 1'b0};
    status_rd[STAT_BUSY] = busy;
  end

  always_comb begin
    case (offset)
      REG_CNT0:      rd_val = cnt_q[15:0];
      REG_CNT1:      rd_val = cnt_q[31:16];
      REG_CNT2:      rd_val = cnt_q[47:32];
      REG_CNT3:      rd_val = cnt_q[63:48];
      REG_STATUS:    rd_val = {8'h00, status_rd};
      REG_TX_WR_PTR: rd_val = WB_DW'(wr_ptr_q);
      REG_TX_RD_PTR: rd_val = WB_DW'(rd_ptr_i);
      REG_STAMP0:    rd_val = stamp_q[15:0];
      REG_STAMP1:    rd_val = stamp_q[31:16];
      REG_STAMP2:    rd_val = stamp_q[47:32];
      // unmapped offsets still ack, reading zero
      default:       rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_125) begin
    if (access) begin
      rd_q <= rd_val;
    end
  end

  assign rsp_o    = '{ack: ack_q, dat: rd_q};
  assign wr_ptr_o = wr_ptr_q;
  assign intr_o   = status_q[STAT_DONE];

endmodule

/* hw/wb_target_mux.sv */
`timescale 1ns/100ps

module wb_target_mux (
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  ethpipe_pkg::wb_req_t wb_req_i,
  input  ethpipe_pkg::wb_rsp_t reg_rsp_i,
  input  ethpipe_pkg::wb_rsp_t mem_rsp_i,
  output logic                 reg_stb_o,
  output logic                 mem_stb_o,
  output ethpipe_pkg::wb_rsp_t wb_rsp_o
);
  import ethpipe_pkg::*;

  logic cyc_stb;
  logic mem_sel;

  // --------------------------------------------------
  // strobe steering
  // --------------------------------------------------

  // a cycle only counts with both cyc and stb
  assign cyc_stb = wb_cyc_i & wb_stb_i;

  // top address bit: 1 is slot memory, 0 is register bank
  assign mem_sel = wb_req_i.adr[WB_AW-1];

  assign reg_stb_o = cyc_stb & ~mem_sel;
  assign mem_stb_o = cyc_stb & mem_sel;

  // --------------------------------------------------
  // response merge
  // --------------------------------------------------

  // master holds the address through the ack cycle,
  // so the same select still picks the right target
  always_comb begin
    wb_rsp_o.ack = mem_sel ? mem_rsp_i.ack : reg_rsp_i.ack;
    // unselected target contributes zero data
    wb_rsp_o.dat = ({WB_DW{mem_sel}} & mem_rsp_i.dat) |
                   ({WB_DW{~mem_sel}} & reg_rsp_i.dat);
  end

endmodule

/* hw/ethpipe_pkg.sv */
package ethpipe_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------

  // word address, top bit picks slot memory over registers
  localparam int WB_AW = 15;
  localparam int WB_DW = 16;
  localparam int WB_SW = 2;

  // free-running counter and captured timestamp
  localparam int CNT_W   = 64;
  localparam int STAMP_W = 48;

  // status register bit positions
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 3;

  // --------------------------------------------------
  // bus structs
  // --------------------------------------------------

  // request fields as driven by the master
  typedef struct packed {
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
    logic [WB_SW-1:0] sel;
  } wb_req_t;

  // response fields as returned by a target
  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  // --------------------------------------------------
  // register map, low 8 bits of the word address
  // --------------------------------------------------
  typedef enum logic [7:0] {
    REG_CNT0      = 8'h02,
    REG_CNT1      = 8'h03,
    REG_CNT2      = 8'h04,
    REG_CNT3      = 8'h05,
    REG_STATUS    = 8'h08,
    REG_TX_WR_PTR = 8'h18,
    REG_TX_RD_PTR = 8'h1A,
    REG_STAMP0    = 8'h80,
    REG_STAMP1    = 8'h81,
    REG_STAMP2    = 8'h82
  } reg_addr_e;

  // slot sender FSM
  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_HIGH,
    S_LOW
  } sender_state_e;

endpackage
